// ==== tb.f ====
hdl/psram_pkg.sv
hdl/qspi_frame_decoder.sv
hdl/nibble_transfer.sv
hdl/psram_array.sv
hdl/psram_top.sv
tests/psram_sva.sv
tests/psram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module psram_tb -f tb.f --Mdir obj_dir -o psram_sim \
    && ./obj_dir/psram_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/psram_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_tb import psram_pkg::*; ();

    localparam int          ADDR_W      = 12;
    localparam int          DEPTH       = 1 << ADDR_W;
    localparam logic [31:0] SEED        = 32'h78aa_2857;
    localparam int          KIND_WRITE  = 0;
    localparam int          KIND_READ   = 1;
    localparam int          KIND_BAD    = 2;
    localparam int          TXNS        = 48;                        // Fill, directed and random
    localparam int          TOTAL_BYTES = DEPTH + 6 * 16 + 40 * 8;
    localparam int          TXN_CYCLES  = 32;                        // Header, wait, deselect
    localparam int          LIMIT       = (2 * TOTAL_BYTES + TXNS * TXN_CYCLES) * 12 / 10;

    logic        sck;
    logic        reset;
    logic [3:0]  dio_in;
    wire  [3:0]  dio_out;
    wire         dio_oe;
    wire         cmd_err;

    logic [7:0]  ref_mem [DEPTH];
    int          errors = 0;
    int          edges = 0;                                          // Rising edges since select
    int          cycles = 0;
    int          txn_kind;
    logic [23:0] txn_addr;

    psram_top #(
        .ADDR_W (ADDR_W)
    ) dut0 (
        .sck     (sck),
        .reset   (reset),
        .dio_in  (dio_in),
        .dio_out (dio_out),
        .dio_oe  (dio_oe),
        .cmd_err (cmd_err)
    );

    initial begin
        sck = 1'b0;
        forever #10 sck = ~sck;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [7:0] fill_pattern(input logic [23:0] addr);
        return addr[7:0] ^ {addr[3:0], addr[11:8]} ^ addr[19:12] ^ {addr[23:20], 4'h5};
    endfunction

    function automatic logic [7:0] expected_byte(input logic [23:0] addr);
        return ref_mem[addr[ADDR_W-1:0]];                            // Address modulo the depth
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // Host side serial driver
    // ----------------------------------------
    task automatic drive_nibble(input logic [3:0] nib);
        @(posedge sck);
        #2;
        dio_in = nib;
    endtask

    task automatic send_cmd(input logic [7:0] cmd);
        for (int i = 7; i >= 0; i--) begin
            @(posedge sck);
            #2;
            if (i == 7)
                reset = 1'b0;                                        // Select with the first bit
            dio_in = {3'b000, cmd[i]};
        end
    endtask

    task automatic send_addr(input logic [23:0] addr);
        for (int i = 5; i >= 0; i--)
            drive_nibble(addr[4 * i +: 4]);
    endtask

    task automatic deselect(input int extra);
        repeat (extra) @(posedge sck);
        #2;
        reset  = 1'b1;
        dio_in = 4'h0;
        @(posedge sck);
    endtask

    task automatic write_burst(input logic [23:0] addr, input int len, input bit patterned);
        logic [23:0] a;
        logic [7:0]  b;
        txn_kind = KIND_WRITE;
        txn_addr = addr;
        send_cmd(cmd_write);
        send_addr(addr);
        for (int i = 0; i < len; i++) begin
            a = addr + 24'(i);
            b = patterned ? fill_pattern(a) : 8'($urandom);
            ref_mem[a[ADDR_W-1:0]] = b;
            drive_nibble(b[7:4]);
            drive_nibble(b[3:0]);
        end
        deselect(2);                                                 // Low nibble edge, then the store
    endtask

    task automatic read_burst(input logic [23:0] addr, input int len);
        txn_kind = KIND_READ;
        txn_addr = addr;
        send_cmd(cmd_read);
        send_addr(addr);
        deselect(7 + 2 * len);                                       // Last address edge and six waits
    endtask

    task automatic bad_command(input logic [7:0] cmd, input logic [23:0] addr);
        txn_kind = KIND_BAD;
        txn_addr = addr;
        send_cmd(cmd);
        send_addr(addr);
        deselect(9);
    endtask

    task automatic finish_run();
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    // ----------------------------------------
    // Compare and timeout
    // ----------------------------------------
    always @(posedge sck) begin
        if (reset)
            edges <= 0;
        else
            edges <= edges + 1;
    end

    // Sampled mid cycle, ahead of the rising edge that the host would use
    always @(negedge sck) begin : compare
        int         n;
        int         k;
        logic       exp_oe;
        logic       exp_err;
        logic [7:0] b;
        exp_oe  = 1'b0;
        exp_err = 1'b0;
        n       = edges - 1;                                         // Edge that opened this cycle
        if (!reset) begin
            exp_oe  = (txn_kind == KIND_READ) && (n >= 19);
            exp_err = (txn_kind == KIND_BAD) && (n >= 13);
        end
        check_value("dio_oe", 8'(exp_oe), 8'(dio_oe));
        check_value("cmd_err", 8'(exp_err), 8'(cmd_err));
        if (exp_oe) begin
            k = n - 19;
            b = expected_byte(txn_addr + 24'(k / 2));
            check_value("dio_out", 8'((k % 2 == 0) ? b[7:4] : b[3:0]), 8'(dio_out));
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge sck);
            cycles = cycles + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        errors = errors + 1;
        finish_run();
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [23:0] addr;
        int          len;
        void'($urandom(SEED));
        reset     = 1'b1;
        dio_in    = 4'h0;
        txn_kind  = KIND_WRITE;
        txn_addr  = '0;
        repeat (4) @(posedge sck);

        write_burst(24'h000000, DEPTH, 1'b1);                        // Known contents everywhere
        write_burst(24'h000120, 16, 1'b0);
        read_burst(24'h000120, 16);
        write_burst(24'h000ff8, 16, 1'b0);                           // Wraps past the top
        read_burst(24'h000ff8, 16);
        read_burst(24'h5a7ff8, 16);                                  // Same bytes through upper bits
        bad_command(8'h5a, 24'h000120);
        read_burst(24'h000120, 16);

        for (int t = 0; t < 40; t++) begin
            addr = 24'($urandom);
            len  = $urandom_range(8, 1);
            if ($urandom_range(1, 0) == 1)
                write_burst(addr, len, 1'b0);
            else
                read_burst(addr, len);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== tests/psram_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_sva (
    input wire sck,
    input wire reset,
    input wire dio_oe,
    input wire cmd_err
);

    // ----------------------------------------
    // Output level rules
    // ----------------------------------------
    oe_err_exclusive: assert property (@(posedge sck) !(dio_oe && cmd_err))
        else $error("dio_oe and cmd_err are high together");

    // Deselect clears the driver and the error flag
    quiet_in_reset: assert property (@(posedge sck) reset |-> (!dio_oe && !cmd_err))
        else $error("dio_oe or cmd_err is high while reset is high");

    err_sticky: assert property (@(posedge sck) (!reset && $past(cmd_err)) |-> cmd_err)
        else $error("cmd_err dropped without a reset");

endmodule

bind psram_top psram_sva sva0 (
    .sck     (sck),
    .reset   (reset),
    .dio_oe  (dio_oe),
    .cmd_err (cmd_err)
);

`default_nettype wire

// ==== hdl/psram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_top import psram_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  wire       sck,
    input  wire       reset,                       // Acts as chip deselect
    input  wire [3:0] dio_in,
    output wire [3:0] dio_out,
    output wire       dio_oe,
    output wire       cmd_err
);

    frame_hdr_t hdr;
    phase_t     phase;
    logic       half;
    mem_req_t   mem_req;
    logic [7:0] rdata;

    // ----------------------------------------
    // Command and address framing
    // ----------------------------------------
    qspi_frame_decoder dec0 (
        .sck     (sck),
        .reset   (reset),
        .dio_in  (dio_in),
        .hdr     (hdr),
        .phase   (phase),
        .half    (half),
        .cmd_err (cmd_err)
    );

    // ----------------------------------------
    // Nibble packing and serializing
    // ----------------------------------------
    nibble_transfer xfer0 (
        .sck     (sck),
        .reset   (reset),
        .dio_in  (dio_in),
        .hdr     (hdr),
        .phase   (phase),
        .half    (half),
        .rdata   (rdata),
        .mem_req (mem_req),
        .dio_out (dio_out),
        .dio_oe  (dio_oe)
    );

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    psram_array #(
        .ADDR_W (ADDR_W)
    ) array0 (
        .sck     (sck),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/psram_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_array import psram_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  wire           sck,
    input  wire mem_req_t mem_req,
    output logic [7:0]    rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0]        mem [DEPTH];
    logic [ADDR_W-1:0] idx;

    // Upper address bits are dropped, so bursts wrap at the top of the array
    assign idx = mem_req.addr[ADDR_W-1:0];

    always_ff @(posedge sck) begin
        if (mem_req.we)
            mem[idx] <= mem_req.wdata;
    end

    assign rdata = mem[idx];                       // Same cycle read

endmodule

`default_nettype wire

// ==== hdl/nibble_transfer.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_transfer import psram_pkg::*; (
    input  wire             sck,
    input  wire             reset,
    input  wire [3:0]       dio_in,
    input  wire frame_hdr_t hdr,
    input  wire phase_t     phase,
    input  wire             half,
    input  wire [7:0]       rdata,
    output mem_req_t        mem_req,
    output logic [3:0]      dio_out,
    output logic            dio_oe
);

    localparam logic [2:0] WAIT_LAST = 3'd5;   // Sixth wait cycle, counted from 0

    logic        loaded;
    logic        burst_start;
    logic [23:0] ptr;
    logic [3:0]  hi_nib;
    logic        we_q;
    logic [7:0]  wdata_q;
    logic [2:0]  wait_cnt;

    // ----------------------------------------
    // Burst address pointer
    // ----------------------------------------
    assign burst_start = !loaded && (phase == ph_wdata || phase == ph_wait);

    always_ff @(posedge sck or posedge reset) begin
        if (reset)
            loaded <= 1'b0;
        else if (burst_start)
            loaded <= 1'b1;
    end

    // Write bursts step once the byte is committed, read bursts after the low nibble
    always_ff @(posedge sck) begin
        if (burst_start)
            ptr <= hdr.addr;
        else if (we_q || (phase == ph_rdata && half))
            ptr <= ptr + 24'd1;
    end

    // ----------------------------------------
    // Write path
    // ----------------------------------------
    always_ff @(posedge sck) begin
        if (phase == ph_wdata) begin
            if (!half)
                hi_nib <= dio_in;
            else
                wdata_q <= {hi_nib, dio_in};
        end
    end

    always_ff @(posedge sck or posedge reset) begin
        if (reset)
            we_q <= 1'b0;
        else
            we_q <= (phase == ph_wdata) && half;   // One cycle strobe per byte
    end

    assign mem_req = '{we: we_q, addr: ptr, wdata: wdata_q};

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
            dio_oe   <= 1'b0;
        end else if (phase == ph_wait && hdr.cmd == cmd_read) begin
            wait_cnt <= wait_cnt + 3'd1;
            if (wait_cnt == WAIT_LAST)
                dio_oe <= 1'b1;                     // Drives from the first data cycle on
        end
    end

    assign dio_out = half ? rdata[3:0] : rdata[7:4];   // High nibble first

endmodule

`default_nettype wire

// ==== hdl/qspi_frame_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module qspi_frame_decoder import psram_pkg::*; (
    input  wire        sck,
    input  wire        reset,
    input  wire [3:0]  dio_in,
    output frame_hdr_t hdr,
    output phase_t     phase,
    output logic       half,
    output logic       cmd_err
);

    localparam logic [4:0] CMD_LAST   = 5'd7;    // Edge of the last command bit
    localparam logic [4:0] ADDR_LAST  = 5'd13;   // Edge of the last address nibble
    localparam logic [4:0] DATA_FIRST = 5'd14;   // First edge after the header
    localparam logic [4:0] WAIT_LAST  = 5'd19;   // Sixth and last wait edge
    localparam logic [4:0] CNT_STOP   = 5'd20;   // Nothing depends on the count past here

    logic [4:0]  cnt;
    logic [7:0]  cmd_sr;
    logic [19:0] addr_sr;
    phase_t      phase_nxt;

    // ----------------------------------------
    // Cycle counter and nibble half
    // ----------------------------------------
    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            half <= 1'b0;
        end else begin
            if (cnt != CNT_STOP)
                cnt <= cnt + 5'd1;
            if (cnt >= DATA_FIRST)
                half <= ~half;                    // Low on every high nibble cycle
        end
    end

    // ----------------------------------------
    // Command and address shifting
    // ----------------------------------------
    always_ff @(posedge sck) begin
        if (phase == ph_cmd)
            cmd_sr <= {cmd_sr[6:0], dio_in[0]};   // Single bit lane, MSB first
        if (phase == ph_addr)
            addr_sr <= {addr_sr[15:0], dio_in};   // Most significant nibble first
    end

    // The sixth nibble is still on the bus, so it goes straight into the header
    always_ff @(posedge sck) begin
        if (phase == ph_addr && cnt == ADDR_LAST)
            hdr <= '{cmd: cmd_sr, addr: {addr_sr, dio_in}};
    end

    // ----------------------------------------
    // Phase sequencing
    // ----------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            ph_cmd: begin
                if (cnt == CMD_LAST)
                    phase_nxt = ph_addr;
            end
            ph_addr: begin
                if (cnt == ADDR_LAST) begin
                    if (cmd_sr == cmd_write)
                        phase_nxt = ph_wdata;
                    else if (cmd_sr == cmd_read)
                        phase_nxt = ph_wait;
                    else
                        phase_nxt = ph_err;       // Frozen until the host deselects
                end
            end
            ph_wait: begin
                if (cnt == WAIT_LAST)
                    phase_nxt = ph_rdata;
            end
            default: begin
                phase_nxt = phase;                // Data and error phases hold
            end
        endcase
    end

    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            phase   <= ph_cmd;
            cmd_err <= 1'b0;
        end else begin
            phase   <= phase_nxt;
            cmd_err <= (phase_nxt == ph_err);     // Rises together with the error phase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/psram_pkg.sv ====
`default_nettype none

package psram_pkg;

    // ----------------------------------------
    // Device phases and command codes
    // ----------------------------------------
    typedef enum logic [2:0] {
        ph_cmd,
        ph_addr,
        ph_wait,
        ph_wdata,
        ph_rdata,
        ph_err
    } phase_t;

    localparam logic [7:0] cmd_write = 8'h38;   // Quad write
    localparam logic [7:0] cmd_read  = 8'heb;   // Fast quad read with six wait cycles

    // ----------------------------------------
    // Stage to stage payloads
    // ----------------------------------------
    typedef struct packed {
        logic [7:0]  cmd;
        logic [23:0] addr;
    } frame_hdr_t;

    typedef struct packed {
        logic        we;
        logic [23:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

endpackage

`default_nettype wire
